// File: verilog/l2_macros.svh
//==========================================================================
// Geometry of the L2 cache: address, word, line and set sizes
//==========================================================================
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

`define ADDR_BITS      32
`define WORD_BITS      32
`define WORDS_PER_LINE 4
`define L2_SETS        16

// Derived field widths of a byte address
`define BYTE_BITS      2
`define OFFSET_BITS    2
`define INDEX_BITS     4
`define LINE_ADDR_BITS (`ADDR_BITS - `OFFSET_BITS - `BYTE_BITS)
`define TAG_BITS       (`LINE_ADDR_BITS - `INDEX_BITS)

`endif

// File: verilog/l2_msg_pkg.sv
//==========================================================================
// Channel message structs and opcode enums
//==========================================================================
`include "l2_macros.svh"

package l2_msg_pkg;

    typedef enum logic {
        CPU_READ,
        CPU_WRITE
    } cpu_op_t;

    typedef enum logic {
        REQ_GET_LINE,
        REQ_PUT_LINE
    } req_op_t;

    typedef logic [`WORDS_PER_LINE-1:0][`WORD_BITS-1:0] line_t;

    // CPU word access, byte address
    typedef struct packed {
        cpu_op_t                op;
        logic [`ADDR_BITS-1:0]  addr;
        logic [`WORD_BITS-1:0]  word;
    } cpu_req_t;

    // Line is only meaningful for put line
    typedef struct packed {
        req_op_t                     op;
        logic [`LINE_ADDR_BITS-1:0]  addr;
        line_t                       line;
    } req_out_t;

    typedef struct packed {
        logic [`LINE_ADDR_BITS-1:0]  addr;
        line_t                       line;
    } rsp_in_t;

    typedef struct packed {
        logic [`LINE_ADDR_BITS-1:0]  addr;
        line_t                       line;
    } rd_rsp_t;

endpackage

// File: verilog/l2_state_pkg.sv
//==========================================================================
// Line state, controller state and tag entry types
//==========================================================================
`include "l2_macros.svh"

package l2_state_pkg;

    typedef enum logic [1:0] {
        LINE_INVALID,
        LINE_CLEAN,
        LINE_DIRTY
    } line_state_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND,
        ST_FLUSH_SCAN,
        ST_FLUSH_WB
    } ctrl_state_t;

    typedef struct packed {
        logic [`TAG_BITS-1:0]  tag;
        line_state_t           state;
    } tag_entry_t;

endpackage

// File: verilog/l2_tag_store.sv
//==========================================================================
// Tag, valid and dirty array, one entry per set
//==========================================================================
`include "l2_macros.svh"

module l2_tag_store
    import l2_state_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`INDEX_BITS-1:0]  index_i,
    input  logic                    wr_en_i,
    input  tag_entry_t              wr_entry_i,
    output tag_entry_t              rd_entry_o
);

    logic [`TAG_BITS-1:0] tag_mem [`L2_SETS];
    line_state_t          state_mem [`L2_SETS];

    // Line states come up invalid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `L2_SETS; i++) begin
                state_mem[i] <= LINE_INVALID;
            end
        end else if (wr_en_i) begin
            state_mem[index_i] <= wr_entry_i.state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[index_i] <= wr_entry_i.tag;
        end
    end

    // Combinational lookup
    assign rd_entry_o.tag   = tag_mem[index_i];
    assign rd_entry_o.state = state_mem[index_i];

endmodule

// File: verilog/l2_data_store.sv
//==========================================================================
// Line data array with whole-line fill and word merge
//==========================================================================
`include "l2_macros.svh"

module l2_data_store
    import l2_msg_pkg::*;
(
    input  logic                     clk,
    input  logic [`INDEX_BITS-1:0]   index_i,
    input  logic                     fill_en_i,
    input  line_t                    fill_line_i,
    input  logic                     merge_en_i,
    input  logic [`OFFSET_BITS-1:0]  word_off_i,
    input  logic [`WORD_BITS-1:0]    word_i,
    output line_t                    line_o
);

    line_t data_mem [`L2_SETS];
    line_t next_line;

    // Merge lands on top of a fill in the same cycle
    always_comb begin
        next_line = fill_en_i ? fill_line_i : data_mem[index_i];
        if (merge_en_i) begin
            next_line[word_off_i] = word_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en_i || merge_en_i) begin
            data_mem[index_i] <= next_line;
        end
    end

    assign line_o = data_mem[index_i];

endmodule

// File: verilog/l2_ctrl.sv
//==========================================================================
// Cache controller FSM: lookup, writeback, fill, response and flush
//==========================================================================
`include "l2_macros.svh"

module l2_ctrl
    import l2_msg_pkg::*;
    import l2_state_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_i,
    // CPU side
    input  logic                     cpu_req_valid_i,
    input  cpu_req_t                 cpu_req_i,
    output logic                     cpu_req_ready_o,
    output logic                     rd_rsp_valid_o,
    output rd_rsp_t                  rd_rsp_o,
    input  logic                     rd_rsp_ready_i,
    input  logic                     flush_valid_i,
    output logic                     flush_ready_o,
    output logic                     flush_done_o,
    // Memory side
    output logic                     req_out_valid_o,
    output req_out_t                 req_out_o,
    input  logic                     req_out_ready_i,
    input  logic                     rsp_in_valid_i,
    input  rsp_in_t                  rsp_in_i,
    output logic                     rsp_in_ready_o,
    // Tag store
    output logic [`INDEX_BITS-1:0]   tag_index_o,
    output logic                     tag_wr_en_o,
    output tag_entry_t               tag_wr_entry_o,
    input  tag_entry_t               tag_rd_entry_i,
    // Data store
    output logic [`INDEX_BITS-1:0]   data_index_o,
    output logic                     fill_en_o,
    output line_t                    fill_line_o,
    output logic                     merge_en_o,
    output logic [`OFFSET_BITS-1:0]  word_off_o,
    output logic [`WORD_BITS-1:0]    word_o,
    input  line_t                    data_line_i
);

    localparam logic [`INDEX_BITS-1:0] LAST_INDEX = `INDEX_BITS'(`L2_SETS - 1);

    ctrl_state_t                 state_q;
    cpu_req_t                    req_q;
    logic [`INDEX_BITS-1:0]      scan_q;

    logic [`LINE_ADDR_BITS-1:0]  req_line_addr;
    logic [`INDEX_BITS-1:0]      req_index;
    logic [`TAG_BITS-1:0]        req_tag;
    logic [`INDEX_BITS-1:0]      index;
    logic                        is_write;
    logic                        hit;
    logic                        flushing;

    assign req_line_addr = req_q.addr[`ADDR_BITS-1 -: `LINE_ADDR_BITS];
    assign req_index     = req_line_addr[`INDEX_BITS-1:0];
    assign req_tag       = req_line_addr[`LINE_ADDR_BITS-1 -: `TAG_BITS];
    assign is_write      = (req_q.op == CPU_WRITE);
    assign flushing      = (state_q == ST_FLUSH_SCAN) || (state_q == ST_FLUSH_WB);
    assign index         = flushing ? scan_q : req_index;

    assign hit = (tag_rd_entry_i.state != LINE_INVALID) && (tag_rd_entry_i.tag == req_tag);

    assign tag_index_o  = index;
    assign data_index_o = index;
    assign fill_line_o  = rsp_in_i.line;
    assign word_off_o   = req_q.addr[`BYTE_BITS +: `OFFSET_BITS];
    assign word_o       = req_q.word;

    // Store write strobes
    always_comb begin
        tag_wr_en_o    = 1'b0;
        tag_wr_entry_o = '{tag: req_tag, state: LINE_DIRTY};
        fill_en_o      = 1'b0;
        merge_en_o     = 1'b0;
        case (state_q)
            ST_LOOKUP: begin
                if (hit && is_write) begin
                    tag_wr_en_o = 1'b1;
                    merge_en_o  = 1'b1;
                end
            end
            ST_FILL_WAIT: begin
                if (rsp_in_valid_i && rsp_in_ready_o) begin
                    tag_wr_en_o          = 1'b1;
                    fill_en_o            = 1'b1;
                    merge_en_o           = is_write;
                    tag_wr_entry_o.state = is_write ? LINE_DIRTY : LINE_CLEAN;
                end
            end
            ST_FLUSH_SCAN, ST_FLUSH_WB: begin
                // Invalidate once the entry needs no more writeback
                if (state_q == ST_FLUSH_WB ? req_out_ready_i
                                           : tag_rd_entry_i.state != LINE_DIRTY) begin
                    tag_wr_en_o    = 1'b1;
                    tag_wr_entry_o = '{tag: tag_rd_entry_i.tag, state: LINE_INVALID};
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q         <= ST_IDLE;
            scan_q          <= '0;
            cpu_req_ready_o <= 1'b1;
            flush_ready_o   <= 1'b1;
            req_out_valid_o <= 1'b0;
            rsp_in_ready_o  <= 1'b0;
            rd_rsp_valid_o  <= 1'b0;
            flush_done_o    <= 1'b0;
        end else begin
            flush_done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // Flush wins over a simultaneous CPU request
                    if (flush_valid_i && flush_ready_o) begin
                        scan_q          <= '0;
                        cpu_req_ready_o <= 1'b0;
                        flush_ready_o   <= 1'b0;
                        state_q         <= ST_FLUSH_SCAN;
                    end else if (cpu_req_valid_i && cpu_req_ready_o) begin
                        req_q           <= cpu_req_i;
                        cpu_req_ready_o <= 1'b0;
                        flush_ready_o   <= 1'b0;
                        state_q         <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit && is_write) begin
                        cpu_req_ready_o <= 1'b1;
                        flush_ready_o   <= 1'b1;
                        state_q         <= ST_IDLE;
                    end else if (hit) begin
                        rd_rsp_valid_o <= 1'b1;
                        rd_rsp_o       <= '{addr: req_line_addr, line: data_line_i};
                        state_q        <= ST_RESPOND;
                    end else if (tag_rd_entry_i.state == LINE_DIRTY) begin
                        req_out_valid_o <= 1'b1;
                        req_out_o.op    <= REQ_PUT_LINE;
                        req_out_o.addr  <= {tag_rd_entry_i.tag, req_index};
                        req_out_o.line  <= data_line_i;
                        state_q         <= ST_WRITEBACK;
                    end else begin
                        req_out_valid_o <= 1'b1;
                        req_out_o.op    <= REQ_GET_LINE;
                        req_out_o.addr  <= req_line_addr;
                        state_q         <= ST_FILL_REQ;
                    end
                end
                ST_WRITEBACK: begin
                    // Victim accepted, follow with the fetch
                    if (req_out_ready_i) begin
                        req_out_o.op   <= REQ_GET_LINE;
                        req_out_o.addr <= req_line_addr;
                        state_q        <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ: begin
                    if (req_out_ready_i) begin
                        req_out_valid_o <= 1'b0;
                        rsp_in_ready_o  <= 1'b1;
                        state_q         <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (rsp_in_valid_i && rsp_in_ready_o) begin
                        rsp_in_ready_o <= 1'b0;
                        if (is_write) begin
                            cpu_req_ready_o <= 1'b1;
                            flush_ready_o   <= 1'b1;
                            state_q         <= ST_IDLE;
                        end else begin
                            rd_rsp_valid_o <= 1'b1;
                            rd_rsp_o       <= '{addr: req_line_addr, line: rsp_in_i.line};
                            state_q        <= ST_RESPOND;
                        end
                    end
                end
                ST_RESPOND: begin
                    if (rd_rsp_ready_i) begin
                        rd_rsp_valid_o  <= 1'b0;
                        cpu_req_ready_o <= 1'b1;
                        flush_ready_o   <= 1'b1;
                        state_q         <= ST_IDLE;
                    end
                end
                ST_FLUSH_SCAN, ST_FLUSH_WB: begin
                    if (state_q == ST_FLUSH_SCAN && tag_rd_entry_i.state == LINE_DIRTY) begin
                        req_out_valid_o <= 1'b1;
                        req_out_o.op    <= REQ_PUT_LINE;
                        req_out_o.addr  <= {tag_rd_entry_i.tag, scan_q};
                        req_out_o.line  <= data_line_i;
                        state_q         <= ST_FLUSH_WB;
                    end else if (state_q == ST_FLUSH_SCAN || req_out_ready_i) begin
                        req_out_valid_o <= 1'b0;
                        if (scan_q == LAST_INDEX) begin
                            flush_done_o    <= 1'b1;
                            cpu_req_ready_o <= 1'b1;
                            flush_ready_o   <= 1'b1;
                            state_q         <= ST_IDLE;
                        end else begin
                            scan_q  <= scan_q + 1'b1;
                            state_q <= ST_FLUSH_SCAN;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/l2_rtl_top.sv
//==========================================================================
// L2 cache top level: controller, tag store and data store
//==========================================================================
`include "l2_macros.svh"

module l2_rtl_top
    import l2_msg_pkg::*;
    import l2_state_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      cpu_req_valid_i,
    input  cpu_req_t  cpu_req_i,
    output logic      cpu_req_ready_o,
    output logic      req_out_valid_o,
    output req_out_t  req_out_o,
    input  logic      req_out_ready_i,
    input  logic      rsp_in_valid_i,
    input  rsp_in_t   rsp_in_i,
    output logic      rsp_in_ready_o,
    output logic      rd_rsp_valid_o,
    output rd_rsp_t   rd_rsp_o,
    input  logic      rd_rsp_ready_i,
    input  logic      flush_valid_i,
    output logic      flush_ready_o,
    output logic      flush_done_o
);

    logic [`INDEX_BITS-1:0]   tag_index;
    logic                     tag_wr_en;
    tag_entry_t               tag_wr_entry;
    tag_entry_t               tag_rd_entry;
    logic [`INDEX_BITS-1:0]   data_index;
    logic                     fill_en;
    line_t                    fill_line;
    logic                     merge_en;
    logic [`OFFSET_BITS-1:0]  word_off;
    logic [`WORD_BITS-1:0]    word;
    line_t                    data_line;

    l2_ctrl l2_ctrl_i (
        .clk,
        .rst_i,
        .cpu_req_valid_i,
        .cpu_req_i,
        .cpu_req_ready_o,
        .rd_rsp_valid_o,
        .rd_rsp_o,
        .rd_rsp_ready_i,
        .flush_valid_i,
        .flush_ready_o,
        .flush_done_o,
        .req_out_valid_o,
        .req_out_o,
        .req_out_ready_i,
        .rsp_in_valid_i,
        .rsp_in_i,
        .rsp_in_ready_o,
        .tag_index_o    (tag_index),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_entry_o (tag_wr_entry),
        .tag_rd_entry_i (tag_rd_entry),
        .data_index_o   (data_index),
        .fill_en_o      (fill_en),
        .fill_line_o    (fill_line),
        .merge_en_o     (merge_en),
        .word_off_o     (word_off),
        .word_o         (word),
        .data_line_i    (data_line)
    );

    l2_tag_store l2_tag_store_i (
        .clk,
        .rst_i,
        .index_i    (tag_index),
        .wr_en_i    (tag_wr_en),
        .wr_entry_i (tag_wr_entry),
        .rd_entry_o (tag_rd_entry)
    );

    l2_data_store l2_data_store_i (
        .clk,
        .index_i     (data_index),
        .fill_en_i   (fill_en),
        .fill_line_i (fill_line),
        .merge_en_i  (merge_en),
        .word_off_i  (word_off),
        .word_i      (word),
        .line_o      (data_line)
    );

endmodule

// File: bench/l2_assertions.sv
//==========================================================================
// Concurrent assertions on the controller handshakes and flush done
//==========================================================================

module l2_assertions
    import l2_msg_pkg::*;
    import l2_state_pkg::*;
(
    input  logic         clk,
    input  logic         rst_i,
    input  ctrl_state_t  state_q,
    input  logic         cpu_req_ready_o,
    input  logic         req_out_valid_o,
    input  req_out_t     req_out_o,
    input  logic         req_out_ready_i,
    input  logic         rd_rsp_valid_o,
    input  rd_rsp_t      rd_rsp_o,
    input  logic         rd_rsp_ready_i,
    input  logic         flush_done_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Stalled payloads hold until the transfer
    req_out_stable: assert property (@(posedge clk) disable iff (rst_i)
        req_out_valid_o && !req_out_ready_i |=> req_out_valid_o && $stable(req_out_o))
        else begin
            $error("outbound request changed while stalled");
            fail_count++;
        end

    rd_rsp_stable: assert property (@(posedge clk) disable iff (rst_i)
        rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_o))
        else begin
            $error("read response changed while stalled");
            fail_count++;
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (rst_i)
        state_q != ST_IDLE |-> !cpu_req_ready_o)
        else begin
            $error("CPU request ready while a request is in progress");
            fail_count++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
        flush_done_o |=> !flush_done_o)
        else begin
            $error("flush done held longer than one cycle");
            fail_count++;
        end

endmodule

bind l2_ctrl l2_assertions l2_assertions_i (.*);

// File: bench/l2_tb.sv
//==========================================================================
// Testbench for the L2 cache: clock, memory model, reference model, checks
//==========================================================================
`include "l2_macros.svh"

module l2_tb
    import l2_msg_pkg::*;
    import l2_state_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Directed operations plus the random run and both flushes
    localparam int N_RANDOM   = 300;
    localparam int N_OPS      = 13 + N_RANDOM;
    localparam int MAX_CYCLES = 200 * N_OPS;

    typedef logic [`LINE_ADDR_BITS-1:0] laddr_t;

    logic      clk;
    logic      rst_i;
    logic      cpu_req_valid_i;
    cpu_req_t  cpu_req_i;
    logic      cpu_req_ready_o;
    logic      req_out_valid_o;
    req_out_t  req_out_o;
    logic      req_out_ready_i;
    logic      rsp_in_valid_i;
    rsp_in_t   rsp_in_i;
    logic      rsp_in_ready_o;
    logic      rd_rsp_valid_o;
    rd_rsp_t   rd_rsp_o;
    logic      rd_rsp_ready_i;
    logic      flush_valid_i;
    logic      flush_ready_o;
    logic      flush_done_o;

    integer      seed = 32'he4fa_b0aa;
    int          cycle_count;
    int          mismatch_count;
    int          protocol_count;
    int          missing_count;
    bit          timed_out;
    bit          flush_active;
    rd_rsp_t     exp_rsp;

    line_t                 shadow [laddr_t];
    line_t                 backing [laddr_t];
    logic [`TAG_BITS-1:0]  model_tag [`L2_SETS];
    line_state_t           model_state [`L2_SETS];
    req_out_t              exp_req_q [$];
    laddr_t                read_q [$];
    laddr_t                get_q [$];

    l2_rtl_top l2_rtl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Each word holds its own byte address, scrambled
    function automatic line_t init_line(laddr_t addr);
        line_t line;
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            line[w] = {addr, 2'(w), 2'b00} ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    function automatic line_t expected_line(laddr_t addr);
        return shadow.exists(addr) ? shadow[addr] : init_line(addr);
    endfunction

    function automatic line_t memory_line(laddr_t addr);
        return backing.exists(addr) ? backing[addr] : init_line(addr);
    endfunction

    task automatic check_rd_rsp(rd_rsp_t got, rd_rsp_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAIL at %0t: read response line %h data %h, expected line %h data %h",
                     $time, got.addr, got.line, exp.addr, exp.line);
        end
    endtask

    task automatic check_req_out(req_out_t got, req_out_t exp);
        // Line data only counts on a put line
        if (got.op !== exp.op || got.addr !== exp.addr ||
            (exp.op == REQ_PUT_LINE && got.line !== exp.line)) begin
            mismatch_count++;
            $display("FAIL at %0t: outbound %s line %h data %h, expected %s line %h data %h",
                     $time, got.op.name(), got.addr, got.line,
                     exp.op.name(), exp.addr, exp.line);
        end
    endtask

    task automatic check_outstanding();
        if (exp_req_q.size() > 0) begin
            missing_count += exp_req_q.size();
            $display("Missing request at %0t: %0d expected outbound request(s) never came",
                     $time, exp_req_q.size());
            exp_req_q.delete();
        end
    endtask

    // Direct-mapped, write-allocate model of which requests go out
    task automatic predict_access(cpu_op_t op, laddr_t addr);
        logic [`INDEX_BITS-1:0]  idx;
        laddr_t                  victim;
        req_out_t                exp;
        idx = addr[`INDEX_BITS-1:0];
        if (model_state[idx] == LINE_INVALID ||
            model_tag[idx] != addr[`LINE_ADDR_BITS-1:`INDEX_BITS]) begin
            if (model_state[idx] == LINE_DIRTY) begin
                victim = {model_tag[idx], idx};
                exp    = '{op: REQ_PUT_LINE, addr: victim, line: expected_line(victim)};
                exp_req_q.push_back(exp);
            end
            exp = '{op: REQ_GET_LINE, addr: addr, line: '0};
            exp_req_q.push_back(exp);
            model_tag[idx]   = addr[`LINE_ADDR_BITS-1:`INDEX_BITS];
            model_state[idx] = LINE_CLEAN;
        end
        if (op == CPU_WRITE) begin
            model_state[idx] = LINE_DIRTY;
        end
    endtask

    task automatic cpu_access(cpu_op_t op, logic [`ADDR_BITS-1:0] addr,
                              logic [`WORD_BITS-1:0] word);
        laddr_t  line_addr;
        line_t   merged;
        line_addr = addr[`ADDR_BITS-1 -: `LINE_ADDR_BITS];
        predict_access(op, line_addr);
        cpu_req_valid_i = 1'b1;
        cpu_req_i       = '{op: op, addr: addr, word: word};
        do @(posedge clk); while (!cpu_req_ready_o);
        if (op == CPU_WRITE) begin
            merged = expected_line(line_addr);
            merged[addr[`BYTE_BITS +: `OFFSET_BITS]] = word;
            shadow[line_addr] = merged;
        end else begin
            read_q.push_back(line_addr);
        end
        @(negedge clk);
        cpu_req_valid_i = 1'b0;
        while (!cpu_req_ready_o || read_q.size() > 0) @(negedge clk);
        check_outstanding();
    endtask

    task automatic flush_cache();
        laddr_t    victim;
        req_out_t  exp;
        for (int i = 0; i < `L2_SETS; i++) begin
            if (model_state[i] == LINE_DIRTY) begin
                victim = {model_tag[i], `INDEX_BITS'(i)};
                exp    = '{op: REQ_PUT_LINE, addr: victim, line: expected_line(victim)};
                exp_req_q.push_back(exp);
            end
            model_state[i] = LINE_INVALID;
        end
        flush_active  = 1'b1;
        flush_valid_i = 1'b1;
        do @(posedge clk); while (!flush_ready_o);
        @(negedge clk);
        flush_valid_i = 1'b0;
        do @(posedge clk); while (!flush_done_o);
        @(negedge clk);
        flush_active = 1'b0;
        check_outstanding();
    endtask

    task automatic finish_run();
        int asserts;
        asserts = l2_rtl_top_i.l2_ctrl_i.l2_assertions_i.fail_count;
        $display("Summary: %0d mismatches, %0d protocol errors, %0d missing, %0d assertions",
                 mismatch_count, protocol_count, missing_count, asserts);
        if (!timed_out && mismatch_count + protocol_count + missing_count + asserts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // Outbound monitor and the memory side of the model
    always @(posedge clk) begin
        if (!rst_i && req_out_valid_o && req_out_ready_i) begin
            if (req_out_o.op == REQ_PUT_LINE) begin
                backing[req_out_o.addr] = req_out_o.line;
            end else begin
                get_q.push_back(req_out_o.addr);
            end
            if (exp_req_q.size() == 0) begin
                protocol_count++;
                $display("Protocol error at %0t: unexpected outbound request for line %h",
                         $time, req_out_o.addr);
            end else begin
                check_req_out(req_out_o, exp_req_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_i && rd_rsp_valid_o && rd_rsp_ready_i) begin
            if (read_q.size() == 0) begin
                protocol_count++;
                $display("Protocol error at %0t: read response with no read pending", $time);
            end else begin
                exp_rsp = '{addr: read_q[0], line: expected_line(read_q[0])};
                check_rd_rsp(rd_rsp_o, exp_rsp);
                void'(read_q.pop_front());
            end
        end
        if (!rst_i && flush_done_o && !flush_active) begin
            protocol_count++;
            $display("Protocol error at %0t: flush done pulse with no flush running", $time);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            timed_out = 1'b1;
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            finish_run();
        end
    end

    // Answers get lines after 0 to 3 cycles
    initial begin : responder
        laddr_t  addr;
        int      delay;
        rsp_in_valid_i = 1'b0;
        rsp_in_i       = '0;
        forever begin
            @(negedge clk);
            if (get_q.size() > 0) begin
                addr  = get_q.pop_front();
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk);
                rsp_in_valid_i = 1'b1;
                rsp_in_i       = '{addr: addr, line: memory_line(addr)};
                do @(posedge clk); while (!rsp_in_ready_o);
                @(negedge clk);
                rsp_in_valid_i = 1'b0;
            end
        end
    end

    // Ready about three cycles in four
    initial begin : back_pressure
        req_out_ready_i = 1'b0;
        rd_rsp_ready_i  = 1'b0;
        forever begin
            @(negedge clk);
            req_out_ready_i = ({$random(seed)} % 4) != 0;
            rd_rsp_ready_i  = ({$random(seed)} % 4) != 0;
        end
    end

    initial begin : main
        logic [`ADDR_BITS-1:0]  addr;
        cpu_op_t                op;
        rst_i           = 1'b1;
        cpu_req_valid_i = 1'b0;
        cpu_req_i       = '0;
        flush_valid_i   = 1'b0;
        for (int i = 0; i < `L2_SETS; i++) begin
            model_state[i] = LINE_INVALID;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // Read miss, then a hit on the same line
        cpu_access(CPU_READ, 32'h0000_1004, '0);
        cpu_access(CPU_READ, 32'h0000_1008, '0);
        // Write hit and write miss, each read back
        cpu_access(CPU_WRITE, 32'h0000_1008, 32'hdead_beef);
        cpu_access(CPU_READ, 32'h0000_1000, '0);
        cpu_access(CPU_WRITE, 32'h0000_2014, 32'h1234_5678);
        cpu_access(CPU_READ, 32'h0000_201c, '0);
        // Conflict on set 2 evicts the dirty line
        cpu_access(CPU_WRITE, 32'h0000_3020, 32'hcafe_f00d);
        cpu_access(CPU_READ, 32'h0004_3020, '0);
        // After a flush everything misses
        flush_cache();
        cpu_access(CPU_READ, 32'h0000_1000, '0);
        cpu_access(CPU_READ, 32'h0000_2010, '0);
        // Clean line of set 2 must be gone too
        cpu_access(CPU_READ, 32'h0004_3024, '0);

        for (int n = 0; n < N_RANDOM; n++) begin
            op   = cpu_op_t'({$random(seed)} % 2);
            addr = 32'h0100_0000 | (({$random(seed)} % 64) << 4) |
                   (({$random(seed)} % 4) << 2);
            cpu_access(op, addr, $random(seed));
        end
        flush_cache();
        finish_run();
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/l2_msg_pkg.sv
verilog/l2_state_pkg.sv
verilog/l2_tag_store.sv
verilog/l2_data_store.sv
verilog/l2_ctrl.sv
verilog/l2_rtl_top.sv
bench/l2_assertions.sv
bench/l2_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l2_msg_pkg.sv
      - verilog/l2_state_pkg.sv
      - verilog/l2_tag_store.sv
      - verilog/l2_data_store.sv
      - verilog/l2_ctrl.sv
      - verilog/l2_rtl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/l2_assertions.sv
      - bench/l2_tb.sv
